// File: cpu_testdata.txt
# I <byte addr> <program word> | D <byte addr> <initial data word>
# E <store addr> <store data>, expected stores in program order
I 00000000 20000513
I 00000004 00C00093
I 00000008 FFB00113
I 0000000C 002081B3
I 00000010 00352023
I 00000014 402081B3
I 00000018 00352223
I 0000001C 00409193
I 00000020 00352423
I 00000024 40115193
I 00000028 00352623
I 0000002C 001121B3
I 00000030 00352823
I 00000034 0020C1B3
I 00000038 00352A23
I 0000003C 0F017193
I 00000040 00352C23
I 00000044 12345237
I 00000048 04452023
I 0000004C 008002EF
I 00000050 04052223
I 00000054 04552423
I 00000058 06300313
I 0000005C 001303E7
I 00000060 04052623
I 00000064 04752823
I 00000068 00108463
I 0000006C 08152023
I 00000070 00109463
I 00000074 08152223
I 00000078 00114463
I 0000007C 08152423
I 00000080 00116463
I 00000084 08252623
I 00000088 00115463
I 0000008C 08152823
I 00000090 00117463
I 00000094 08152A23
I 00000098 0C452023
I 0000009C 0C052183
I 000000A0 0C352223
I 000000A4 18052183
I 000000A8 0C352423
I 000000AC 06300013
I 000000B0 10052023
I 000000B4 00000000
D 00000380 CAFE1234
E 00000200 00000007
E 00000204 00000011
E 00000208 000000C0
E 0000020C FFFFFFFD
E 00000210 00000001
E 00000214 FFFFFFF7
E 00000218 000000F0
E 00000240 12345000
E 00000248 00000050
E 00000250 00000060
E 00000284 0000000C
E 0000028C FFFFFFFB
E 00000290 0000000C
E 000002C0 12345000
E 000002C4 12345000
E 000002C8 CAFE1234
E 00000300 00000000

// File: sim.f
cpu_pkg.sv
cpu_buses.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
alu.sv
execute_stage.sv
cpu_core.sv
tb_clock_gen.sv
tb_cpu_core.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - cpu_pkg.sv
  - cpu_buses.sv
  - reg_file.sv
  - fetch_stage.sv
  - decode_stage.sv
  - alu.sv
  - execute_stage.sv
  - cpu_core.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_cpu_core.sv

// File: tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core;
    import cpu_pkg::*;

    localparam int MEM_WORDS   = 256;
    localparam int HALT_CYCLES = 20;

    logic  clk;
    logic  native_rstn;
    word_t inst_addr;
    logic  inst_rd;
    word_t inst_data;
    word_t mem_addr;
    word_t mem_wdata;
    logic  mem_we;
    logic  mem_rd;
    word_t mem_rdata;
    logic  halted;

    // instruction rom and data ram, both cover byte addresses 0 to 0x3ff
    word_t rom [MEM_WORDS];
    logic  rom_valid [MEM_WORDS];
    word_t ram [MEM_WORDS];

    // expected stores in program order
    word_t exp_addr [$];
    word_t exp_data [$];
    int    exp_idx = 0;
    int    inst_count = 0;

    tb_clock_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (8)
    ) u_clock_gen (
        .clk         (clk),
        .native_rstn (native_rstn)
    );

    cpu_core u_cpu_core (
        .clk         (clk),
        .native_rstn (native_rstn),
        .inst_addr   (inst_addr),
        .inst_rd     (inst_rd),
        .inst_data   (inst_data),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_we      (mem_we),
        .mem_rd      (mem_rd),
        .mem_rdata   (mem_rdata),
        .halted      (halted)
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // store regions of the program, one per behavior
    function automatic string test_for_addr(input word_t addr);
        if (addr < 32'h240) begin
            return "alu";
        end else if (addr < 32'h280) begin
            return "lui_jump";
        end else if (addr < 32'h2c0) begin
            return "branch";
        end else if (addr < 32'h300) begin
            return "load_store";
        end else begin
            return "x0";
        end
    endfunction

    function automatic logic in_mem_range(input word_t addr);
        return (addr[XLEN-1:10] == '0) && (addr[1:0] == 2'b00);
    endfunction

    task automatic load_testdata();
        int    fd;
        int    ch;
        int    n;
        word_t a;
        word_t b;
        fd = $fopen("cpu_testdata.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open cpu_testdata.txt");
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom_valid[i] = 1'b0;
            rom[i]       = '0;
            // unwritten ram words carry their own address
            ram[i]       = 32'hbad0_0000 | (i << 2);
        end
        ch = $fgetc(fd);
        while (ch != -1) begin
            if (ch == "#") begin
                while ((ch != -1) && (ch != "\n")) begin
                    ch = $fgetc(fd);
                end
            end else if ((ch == "I") || (ch == "D") || (ch == "E")) begin
                n = $fscanf(fd, "%h %h", a, b);
                if (n != 2) begin
                    stop_with_failure("malformed line in cpu_testdata.txt");
                end
                if ((ch != "E") && !in_mem_range(a)) begin
                    stop_with_failure($sformatf("data file address %h out of range", a));
                end
                if (ch == "I") begin
                    rom[a[9:2]]       = b;
                    rom_valid[a[9:2]] = 1'b1;
                    inst_count++;
                end else if (ch == "D") begin
                    ram[a[9:2]] = b;
                end else begin
                    exp_addr.push_back(a);
                    exp_data.push_back(b);
                end
            end else if ((ch != " ") && (ch != "\n") && (ch != "\r") && (ch != "\t")) begin
                stop_with_failure($sformatf("unknown tag %c in cpu_testdata.txt", ch));
            end
            ch = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    // rom answers one cycle after inst_rd
    always @(posedge clk) begin
        if (inst_rd === 1'b1) begin
            assert (in_mem_range(inst_addr) && rom_valid[inst_addr[9:2]]) else
                stop_with_failure($sformatf("fetch from %h where no program word was loaded",
                                            inst_addr));
            inst_data <= rom[inst_addr[9:2]];
        end
    end

    // ram answers one cycle after mem_rd, writes on mem_we
    always @(posedge clk) begin
        if (mem_rd === 1'b1) begin
            assert (in_mem_range(mem_addr)) else
                stop_with_failure($sformatf("load from %h outside the data RAM", mem_addr));
            mem_rdata <= ram[mem_addr[9:2]];
        end
        if (mem_we === 1'b1) begin
            assert (in_mem_range(mem_addr)) else
                stop_with_failure($sformatf("store to %h outside the data RAM", mem_addr));
            assert (exp_idx < exp_addr.size()) else
                stop_with_failure($sformatf("store of %h to %h after the last expected store",
                                            mem_wdata, mem_addr));
            assert ((mem_addr == exp_addr[exp_idx]) && (mem_wdata == exp_data[exp_idx])) else
                stop_with_failure($sformatf(
                    "Mismatch %s store %0d: expected %h at %h, actual %h at %h",
                    test_for_addr(exp_addr[exp_idx]), exp_idx, exp_data[exp_idx],
                    exp_addr[exp_idx], mem_wdata, mem_addr));
            ram[mem_addr[9:2]] <= mem_wdata;
            exp_idx <= exp_idx + 1;
        end
    end

    initial begin
        int limit;
        int cycles;
        inst_data = '0;
        mem_rdata = '0;
        load_testdata();
        limit  = 10 * inst_count * 8;
        cycles = 0;

        while (native_rstn !== 1'b1) begin
            @(posedge clk);
        end

        // run until the core halts on the zero word
        while (halted !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles >= limit) begin
                stop_with_failure($sformatf("core never halted within %0d cycles", limit));
            end
        end

        assert (exp_idx == exp_addr.size()) else
            stop_with_failure($sformatf("core halted after %0d of %0d expected stores",
                                        exp_idx, exp_addr.size()));

        // a halted core stays quiet
        repeat (HALT_CYCLES) begin
            @(posedge clk);
            assert ((halted === 1'b1) && (inst_rd === 1'b0) && (mem_we === 1'b0)) else
                stop_with_failure("core left halt or raised a strobe after halting");
        end

        $display("TEST OK");
        $finish;
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic native_rstn
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // reset low for the first cycles, released on a rising edge
    initial begin
        native_rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        native_rstn <= 1'b1;
    end

endmodule

// File: cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
    input  logic           clk,
    input  logic           native_rstn,
    output cpu_pkg::word_t inst_addr,
    output logic           inst_rd,
    input  cpu_pkg::word_t inst_data,
    output cpu_pkg::word_t mem_addr,
    output cpu_pkg::word_t mem_wdata,
    output logic           mem_we,
    output logic           mem_rd,
    input  cpu_pkg::word_t mem_rdata,
    output logic           halted
);
    import cpu_pkg::*;

    core_state_t state;
    word_t       pc;
    word_t       inst;
    word_t       next_pc;
    word_t       wr_data;
    word_t       npc_q;
    word_t       wb_data_q;
    logic        wb_en_q;
    logic        wr_en;
    logic        wb_en;
    logic        fetch_start;
    logic        fetch_done;
    logic        decode_en;
    logic        exec_start;
    logic        exec_done;

    dec_bus     dec_if ();
    rf_read_bus rf_if ();

    // one-cycle start strobes come straight from the state
    assign fetch_start = (state == ST_FETCH);
    assign decode_en   = (state == ST_DECODE);
    assign exec_start  = (state == ST_EXECUTE) && (dec_if.cls != CLS_ILLEGAL);
    assign wb_en       = (state == ST_WRITE) && wb_en_q;
    assign halted      = (state == ST_HALT);

    fetch_stage u_fetch (
        .clk         (clk),
        .native_rstn (native_rstn),
        .fetch_start (fetch_start),
        .pc          (pc),
        .inst_addr   (inst_addr),
        .inst_rd     (inst_rd),
        .inst_data   (inst_data),
        .inst        (inst),
        .fetch_done  (fetch_done)
    );

    decode_stage u_decode (
        .clk         (clk),
        .native_rstn (native_rstn),
        .decode_en   (decode_en),
        .inst        (inst),
        .pc          (pc),
        .rf          (rf_if.decode),
        .dec         (dec_if.decode)
    );

    // rd stays valid in dec_if until the next decode
    reg_file u_reg_file (
        .clk         (clk),
        .native_rstn (native_rstn),
        .rf          (rf_if.regfile),
        .wb_en       (wb_en),
        .wb_addr     (dec_if.rd_addr),
        .wb_data     (wb_data_q)
    );

    execute_stage u_execute (
        .clk         (clk),
        .native_rstn (native_rstn),
        .exec_start  (exec_start),
        .dec         (dec_if.execute),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_we      (mem_we),
        .mem_rd      (mem_rd),
        .mem_rdata   (mem_rdata),
        .exec_done   (exec_done),
        .next_pc     (next_pc),
        .wr_en       (wr_en),
        .wr_data     (wr_data)
    );

    // stage sequencer
    always_ff @(posedge clk) begin
        if (!native_rstn) begin
            state   <= ST_FETCH;
            pc      <= RESET_PC;
            wb_en_q <= 1'b0;
        end else begin
            case (state)
                ST_FETCH: state <= ST_FETCH_WAIT;
                ST_FETCH_WAIT: begin
                    if (fetch_done) begin
                        state <= ST_DECODE;
                    end
                end
                ST_DECODE: state <= ST_EXECUTE;
                ST_EXECUTE: begin
                    // unknown opcode ends the run
                    state <= (dec_if.cls == CLS_ILLEGAL) ? ST_HALT : ST_EXECUTE_WAIT;
                end
                ST_EXECUTE_WAIT: begin
                    if (exec_done) begin
                        wb_en_q <= wr_en;
                        state   <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    pc    <= {npc_q[XLEN-1:2], 2'b00};
                    state <= ST_FETCH;
                end
                default: state <= ST_HALT;
            endcase
        end
    end

    // write-back holding register
    always_ff @(posedge clk) begin
        if ((state == ST_EXECUTE_WAIT) && exec_done) begin
            wb_data_q <= wr_data;
            npc_q     <= next_pc;
        end
    end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic           clk,
    input  logic           native_rstn,
    input  logic           exec_start,
    dec_bus.execute        dec,
    output cpu_pkg::word_t mem_addr,
    output cpu_pkg::word_t mem_wdata,
    output logic           mem_we,
    output logic           mem_rd,
    input  cpu_pkg::word_t mem_rdata,
    output logic           exec_done,
    output cpu_pkg::word_t next_pc,
    output logic           wr_en,
    output cpu_pkg::word_t wr_data
);
    import cpu_pkg::*;

    word_t alu_y;
    word_t seq_pc;
    word_t res_q;
    logic  take_branch;
    logic  is_load;
    logic  is_mem;
    logic  mem_busy;

    alu u_alu (
        .func3   (dec.func3),
        .alt     (dec.alt),
        .use_imm (dec.use_imm),
        .a       (dec.opa),
        .b       (dec.opb),
        .y       (alu_y)
    );

    assign seq_pc  = dec.pc + PC_STEP;
    assign is_load = (dec.cls == CLS_MEM_LOAD);
    assign is_mem  = is_load || (dec.cls == CLS_MEM_STORE);

    always_comb begin
        case (dec.func3)
            F3_BEQ:  take_branch = (dec.opa == dec.opb);
            F3_BNE:  take_branch = (dec.opa != dec.opb);
            F3_BLT:  take_branch = ($signed(dec.opa) < $signed(dec.opb));
            F3_BGE:  take_branch = ($signed(dec.opa) >= $signed(dec.opb));
            F3_BLTU: take_branch = (dec.opa < dec.opb);
            F3_BGEU: take_branch = (dec.opa >= dec.opb);
            default: take_branch = 1'b0;
        endcase
    end

    // data port, strobes only in the start cycle
    assign mem_addr  = dec.target;
    assign mem_wdata = dec.opb;
    assign mem_rd    = exec_start && is_load;
    assign mem_we    = exec_start && (dec.cls == CLS_MEM_STORE);

    always_comb begin
        case (dec.cls)
            CLS_BRANCH: next_pc = take_branch ? dec.target : seq_pc;
            CLS_JUMP:   next_pc = dec.target;
            default:    next_pc = seq_pc;
        endcase
    end

    // branches and stores leave the register file alone
    assign wr_en   = (dec.cls == CLS_ALU) || (dec.cls == CLS_JUMP) ||
                     (dec.cls == CLS_SUBST) || is_load;
    assign wr_data = res_q;

    // memory ops take one extra cycle
    always_ff @(posedge clk) begin
        if (!native_rstn) begin
            mem_busy  <= 1'b0;
            exec_done <= 1'b0;
        end else begin
            mem_busy  <= exec_start && is_mem;
            exec_done <= (exec_start && !is_mem) || mem_busy;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_start) begin
            case (dec.cls)
                CLS_ALU:   res_q <= alu_y;
                CLS_JUMP:  res_q <= seq_pc;
                CLS_SUBST: res_q <= dec.opa;
                default:   res_q <= res_q;
            endcase
        end else if (mem_busy && is_load) begin
            // load data arrives one cycle after mem_rd
            res_q <= mem_rdata;
        end
    end

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [2:0]     func3,
    input  logic           alt,
    input  logic           use_imm,
    input  cpu_pkg::word_t a,
    input  cpu_pkg::word_t b,
    output cpu_pkg::word_t y
);
    import cpu_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (func3)
            // bit 30 of an immediate is part of the constant, not a sub flag
            F3_ADD:  y = (alt && !use_imm) ? a - b : a + b;
            F3_SLL:  y = a << shamt;
            F3_SLT:  y = {{(XLEN-1){1'b0}}, lt_s};
            F3_SLTU: y = {{(XLEN-1){1'b0}}, lt_u};
            F3_XOR:  y = a ^ b;
            F3_SR:   y = alt ? word_t'($signed(a) >>> shamt) : a >> shamt;
            F3_OR:   y = a | b;
            F3_AND:  y = a & b;
            default: y = a + b;
        endcase
    end

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic           clk,
    input  logic           native_rstn,
    input  logic           decode_en,
    input  cpu_pkg::word_t inst,
    input  cpu_pkg::word_t pc,
    rf_read_bus.decode     rf,
    dec_bus.decode         dec
);
    import cpu_pkg::*;

    opcode_t     opcode;
    inst_class_t cls;
    word_t       imm_i;
    word_t       imm_s;
    word_t       imm_b;
    word_t       imm_u;
    word_t       imm_j;
    word_t       addr_sum;
    word_t       target;
    word_t       opa;
    word_t       opb;

    assign opcode      = opcode_t'(inst[6:0]);
    assign rf.rs1_addr = inst[19:15];
    assign rf.rs2_addr = inst[24:20];

    // immediates, all sign extended from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        cls = CLS_ILLEGAL;
        case (opcode)
            OPC_OP, OPC_OP_IMM: cls = CLS_ALU;
            OPC_LUI:            cls = CLS_SUBST;
            OPC_JAL, OPC_JALR:  cls = CLS_JUMP;
            OPC_BRANCH:         cls = CLS_BRANCH;
            OPC_LOAD:           cls = (inst[14:12] == F3_WORD) ? CLS_MEM_LOAD : CLS_ILLEGAL;
            OPC_STORE:          cls = (inst[14:12] == F3_WORD) ? CLS_MEM_STORE : CLS_ILLEGAL;
            default:            cls = CLS_ILLEGAL;
        endcase
    end

    // base plus offset, shared by jalr, load and store
    assign addr_sum = rf.rs1_data + ((opcode == OPC_STORE) ? imm_s : imm_i);

    always_comb begin
        case (opcode)
            OPC_BRANCH: target = pc + imm_b;
            OPC_JAL:    target = pc + imm_j;
            OPC_JALR:   target = {addr_sum[XLEN-1:1], 1'b0};
            default:    target = addr_sum;
        endcase
    end

    // lui carries its value in opa
    assign opa = (opcode == OPC_LUI) ? imm_u : rf.rs1_data;
    assign opb = (opcode == OPC_OP_IMM) ? imm_i : rf.rs2_data;

    always_ff @(posedge clk) begin
        if (!native_rstn) begin
            // nothing decoded yet
            dec.cls     <= CLS_ILLEGAL;
            dec.func3   <= '0;
            dec.alt     <= 1'b0;
            dec.use_imm <= 1'b0;
        end else if (decode_en) begin
            dec.cls     <= cls;
            dec.func3   <= inst[14:12];
            dec.alt     <= inst[30];
            dec.use_imm <= (opcode == OPC_OP_IMM);
        end
    end

    always_ff @(posedge clk) begin
        if (decode_en) begin
            dec.opa     <= opa;
            dec.opb     <= opb;
            dec.target  <= target;
            dec.rd_addr <= inst[11:7];
            dec.pc      <= pc;
        end
    end

endmodule

// File: fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic           clk,
    input  logic           native_rstn,
    input  logic           fetch_start,
    input  cpu_pkg::word_t pc,
    output cpu_pkg::word_t inst_addr,
    output logic           inst_rd,
    input  cpu_pkg::word_t inst_data,
    output cpu_pkg::word_t inst,
    output logic           fetch_done
);
    import cpu_pkg::*;

    // read strobe follows the start strobe, address is word aligned
    assign inst_rd   = fetch_start;
    assign inst_addr = {pc[XLEN-1:2], 2'b00};

    // memory answers one cycle after the strobe
    always_ff @(posedge clk) begin
        if (!native_rstn) begin
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= fetch_start;
        end
    end

    // grab the word in the cycle it is on the bus
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            inst <= inst_data;
        end
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               native_rstn,
    rf_read_bus.regfile        rf,
    input  logic               wb_en,
    input  cpu_pkg::reg_addr_t wb_addr,
    input  cpu_pkg::word_t     wb_data
);
    import cpu_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!native_rstn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_addr != '0)) begin
            // x0 never takes a write, so it reads zero
            regs[wb_addr] <= wb_data;
        end
    end

    // asynchronous reads, decode samples them in the same cycle
    assign rf.rs1_data = regs[rf.rs1_addr];
    assign rf.rs2_data = regs[rf.rs2_addr];

endmodule

// File: cpu_buses.sv
`timescale 1ns/1ps

// decoded instruction, written by decode and held for execute
interface dec_bus;
    import cpu_pkg::*;

    inst_class_t cls;
    logic [2:0]  func3;
    logic        alt;
    logic        use_imm;
    word_t       opa;
    word_t       opb;
    word_t       target;
    reg_addr_t   rd_addr;
    word_t       pc;

    modport decode (output cls, func3, alt, use_imm, opa, opb, target, rd_addr, pc);
    modport execute (input cls, func3, alt, use_imm, opa, opb, target, rd_addr, pc);
endinterface

// register file read ports
interface rf_read_bus;
    import cpu_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    modport decode (output rs1_addr, rs2_addr, input rs1_data, rs2_data);
    modport regfile (input rs1_addr, rs2_addr, output rs1_data, rs2_data);
endinterface

// File: cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t PC_STEP  = 32'd4;
    localparam word_t RESET_PC = 32'h0000_0000;

    // rv32i major opcodes that the core understands
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_t;

    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_MEM_LOAD,
        CLS_MEM_STORE,
        CLS_BRANCH,
        CLS_JUMP,
        CLS_SUBST,
        CLS_ILLEGAL
    } inst_class_t;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_FETCH_WAIT,
        ST_DECODE,
        ST_EXECUTE,
        ST_EXECUTE_WAIT,
        ST_WRITE,
        ST_HALT
    } core_state_t;

    // alu func3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // branch func3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // only full words go to data memory
    localparam logic [2:0] F3_WORD = 3'b010;

endpackage
